//--- dv/regReadTb.sv
// Register read testbench
`include "regRead_settings.svh"

module regReadTb;

  timeunit 1ns;
  timeprecision 100ps;

  import regReadPkg::*;

  localparam int clkPeriod = 40;
  localparam int driveDelay = 2;
  localparam int fillCycles = `RR_PHYS_REGS / `RR_LANES;
  localparam int randCycles = 600;
  localparam int numCycles = 2 + fillCycles + randCycles + 4;

  logic clk = 1'b0;
  logic reset_i;
  issuePacketT fuPacket_i [`RR_LANES];
  logic [`RR_LANES-1:0] fuPacketValid_i;
  bypassT bypass_i [`RR_LANES];
  tagReqT wakeup_i [`RR_LANES];
  tagReqT unmap_i [`RR_LANES];
  logic ctrlVerified_i;
  logic ctrlMispredict_i;
  logic [`RR_CHECKPOINT_LOG-1:0] ctrlCheckpoint_i;
  logic recoverFlag_i;
  logic exceptionFlag_i;
  readPacketT fuPacket_o [`RR_LANES];
  logic [`RR_LANES-1:0] fuPacketValid_o;
  logic [`RR_PHYS_REGS-1:0] phyRegRdy_o;

  string testName = "reset";

  always #(clkPeriod / 2) clk = ~clk;

  regRead DUT (.*);

  task automatic nextCycle();
    @(posedge clk);
    #(driveDelay);
  endtask

  task automatic idleInputs();
    for (int l = 0; l < `RR_LANES; l++) begin
      fuPacket_i[l] = '0;
      bypass_i[l] = '0;
      wakeup_i[l] = '0;
      unmap_i[l] = '0;
    end
    fuPacketValid_i = '0;
    ctrlVerified_i = 1'b0;
    ctrlMispredict_i = 1'b0;
    ctrlCheckpoint_i = '0;
    recoverFlag_i = 1'b0;
    exceptionFlag_i = 1'b0;
  endtask

  // half the tags come from a small pool so bypass hits and collisions happen.
  function automatic physTagT pickTag();
    logic [31:0] rnd;
    rnd = $urandom();
    return rnd[31] ? physTagT'(rnd[2:0]) : rnd[`RR_PHYS_LOG-1:0];
  endfunction

  function automatic issuePacketT randomPacket();
    issuePacketT pkt;
    logic [31:0] rnd;
    rnd = $urandom();
    pkt.branchMask = rnd[`RR_CHECKPOINTS-1:0];
    pkt.src1 = pickTag();
    pkt.src2 = pickTag();
    pkt.dest = rnd[8 +: `RR_PHYS_LOG];
    pkt.opcode = opcodeT'(rnd[31:16] % 5);
    return pkt;
  endfunction

  task automatic driveRandom();
    logic [31:0] rnd;
    rnd = $urandom();
    for (int l = 0; l < `RR_LANES; l++) begin
      fuPacket_i[l] = randomPacket();
      fuPacketValid_i[l] = rnd[16 + l];
      bypass_i[l] = '{valid: rnd[18 + l], dest: pickTag(), data: $urandom()};
      wakeup_i[l] = '{valid: rnd[20 + l], tag: pickTag()};
      unmap_i[l] = '{valid: rnd[22 + l], tag: pickTag()};
    end
    // both ports on one register to reach the write and forward priorities.
    if (rnd[12]) begin
      bypass_i[`RR_LANES-1].dest = bypass_i[0].dest;
    end
    ctrlVerified_i = rnd[8];
    ctrlMispredict_i = rnd[9];
    ctrlCheckpoint_i = rnd[10 +: `RR_CHECKPOINT_LOG];
    recoverFlag_i = rnd[2:0] == 3'd0;
    exceptionFlag_i = rnd[30:26] == 5'd0;
  endtask

  initial begin
    #((numCycles + 20) * clkPeriod);
    $display("Regression failed");
    $fatal(1, "watchdog expired before the tests finished");
  end

  initial begin
    @(posedge DUT.uChecker.failSeen);
    $display("MISMATCH test=%s check=%s expected=%h actual=%h", testName,
             DUT.uChecker.failCheck, DUT.uChecker.failExp, DUT.uChecker.failAct);
    $display("Regression failed");
    $fatal(1, "a checker assertion failed");
  end

  initial begin
    void'($urandom(32'hbac14ea2));
    idleInputs();
    reset_i = 1'b1;
    repeat (2) @(posedge clk);
    #(driveDelay);
    reset_i = 1'b0;

    // write every register once so later reads have a known value.
    testName = "fill";
    for (int r = 0; r < `RR_PHYS_REGS; r += `RR_LANES) begin
      for (int l = 0; l < `RR_LANES; l++) begin
        bypass_i[l] = '{valid: 1'b1, dest: physTagT'(r + l), data: $urandom()};
        fuPacket_i[l] = randomPacket();
        fuPacketValid_i[l] = 1'b1;
      end
      nextCycle();
    end

    testName = "random";
    repeat (randCycles) begin
      driveRandom();
      nextCycle();
    end

    // the exception overrides the requests beside it, then wakeup beats unmap.
    testName = "exception";
    idleInputs();
    exceptionFlag_i = 1'b1;
    wakeup_i[0] = '{valid: 1'b1, tag: physTagT'(40)};
    unmap_i[0] = '{valid: 1'b1, tag: physTagT'(5)};
    nextCycle();
    idleInputs();
    wakeup_i[0] = '{valid: 1'b1, tag: physTagT'(41)};
    unmap_i[0] = '{valid: 1'b1, tag: physTagT'(41)};
    nextCycle();
    idleInputs();
    nextCycle();
    nextCycle();

    if (DUT.uChecker.failSeen) begin
      $display("Regression failed");
      $fatal(1, "a checker assertion failed");
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

//--- dv/regRead_assertions.sv
// Register read checker
`include "regRead_settings.svh"

module regReadChecker (
  input  logic                          clk,
  input  logic                          reset_i,
  input  regReadPkg::issuePacketT       fuPacket_i [`RR_LANES],
  input  logic [`RR_LANES-1:0]          fuPacketValid_i,
  input  regReadPkg::bypassT            bypass_i [`RR_LANES],
  input  regReadPkg::tagReqT            wakeup_i [`RR_LANES],
  input  regReadPkg::tagReqT            unmap_i [`RR_LANES],
  input  logic                          ctrlVerified_i,
  input  logic                          ctrlMispredict_i,
  input  logic [`RR_CHECKPOINT_LOG-1:0] ctrlCheckpoint_i,
  input  logic                          recoverFlag_i,
  input  logic                          exceptionFlag_i,
  input  regReadPkg::readPacketT        fuPacket_o [`RR_LANES],
  input  logic [`RR_LANES-1:0]          fuPacketValid_o,
  input  logic [`RR_PHYS_REGS-1:0]      phyRegRdy_o
);

  import regReadPkg::*;

  localparam int dw = `RR_DATA_W;
  localparam int nOps = 2 * `RR_LANES;
  localparam int opBits = nOps * dw;
  localparam int pktBits = $bits(issuePacketT);

  // registers below the architectural count are ready out of reset.
  function automatic logic [`RR_PHYS_REGS-1:0] archReady();
    logic [`RR_PHYS_REGS-1:0] v;
    v = '0;
    for (int r = 0; r < `RR_ARCH_REGS; r++) begin
      v[r] = 1'b1;
    end
    return v;
  endfunction

  localparam logic [`RR_PHYS_REGS-1:0] archRdy = archReady();

  dataT shadowRegs [`RR_PHYS_REGS];
  logic [`RR_PHYS_REGS-1:0] shadowWritten;
  logic [`RR_PHYS_REGS-1:0] shadowRdy;
  logic [opBits-1:0] expFile;
  logic [opBits-1:0] actFile;
  logic [opBits-1:0] expFwd;
  logic [opBits-1:0] actFwd;
  logic [`RR_LANES-1:0] expValid;
  logic [`RR_LANES*pktBits-1:0] inFields;
  logic [`RR_LANES*pktBits-1:0] outFields;

  logic failSeen = 1'b0;
  string failCheck;
  logic [opBits-1:0] failExp;
  logic [opBits-1:0] failAct;

  // port order makes the higher write port land last.
  always_ff @(posedge clk) begin
    if (reset_i) begin
      shadowWritten <= '0;
    end else if (!recoverFlag_i) begin
      for (int p = 0; p < `RR_LANES; p++) begin
        if (bypass_i[p].valid) begin
          shadowRegs[bypass_i[p].dest] <= bypass_i[p].data;
          shadowWritten[bypass_i[p].dest] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i || exceptionFlag_i) begin
      shadowRdy <= archRdy;
    end else begin
      for (int u = 0; u < `RR_LANES; u++) begin
        if (unmap_i[u].valid) begin
          shadowRdy[unmap_i[u].tag] <= 1'b0;
        end
      end
      for (int k = 0; k < `RR_LANES; k++) begin
        if (wakeup_i[k].valid) begin
          shadowRdy[wakeup_i[k].tag] <= 1'b1;
        end
      end
    end
  end

  // split each operand into a forwarded slot or a file slot.
  always_comb begin
    physTagT tag;
    dataT actual;
    dataT fwdData;
    logic found;
    expFile = '0;
    actFile = '0;
    expFwd = '0;
    actFwd = '0;
    for (int s = 0; s < nOps; s++) begin
      tag = s[0] ? fuPacket_i[s/2].src2 : fuPacket_i[s/2].src1;
      actual = s[0] ? fuPacket_o[s/2].srcData2 : fuPacket_o[s/2].srcData1;
      found = 1'b0;
      fwdData = '0;
      for (int p = 0; p < `RR_LANES; p++) begin
        if (!found && bypass_i[p].valid && bypass_i[p].dest == tag) begin
          found = 1'b1;
          fwdData = bypass_i[p].data;
        end
      end
      if (found) begin
        expFwd[s*dw +: dw] = fwdData;
        actFwd[s*dw +: dw] = actual;
      end else if (shadowWritten[tag]) begin
        expFile[s*dw +: dw] = shadowRegs[tag];
        actFile[s*dw +: dw] = actual;
      end
    end
  end

  // a verified mispredict kills every packet that depends on its checkpoint.
  always_comb begin
    logic [`RR_CHECKPOINTS-1:0] killMask;
    killMask = '0;
    if (ctrlVerified_i && ctrlMispredict_i) begin
      killMask[ctrlCheckpoint_i] = 1'b1;
    end
    for (int l = 0; l < `RR_LANES; l++) begin
      expValid[l] = fuPacketValid_i[l] && ((fuPacket_i[l].branchMask & killMask) == '0);
      inFields[l*pktBits +: pktBits] = fuPacket_i[l];
      outFields[l*pktBits +: pktBits] = fuPacket_o[l].packet;
    end
  end

  task automatic noteFailure(input string check, input logic [opBits-1:0] expected,
                             input logic [opBits-1:0] actual);
    failCheck = check;
    failExp = expected;
    failAct = actual;
    failSeen = 1'b1;
    $error("%s check failed", check);
  endtask

  fileReadA: assert property (@(posedge clk) disable iff (reset_i) actFile == expFile)
    else noteFailure("register read", $sampled(expFile), $sampled(actFile));

  forwardA: assert property (@(posedge clk) disable iff (reset_i) actFwd == expFwd)
    else noteFailure("bypass forward", $sampled(expFwd), $sampled(actFwd));

  squashA: assert property (@(posedge clk) fuPacketValid_o == expValid)
    else noteFailure("mispredict squash", opBits'($sampled(expValid)),
                     opBits'($sampled(fuPacketValid_o)));

  passA: assert property (@(posedge clk) outFields == inFields)
    else noteFailure("packet fields", opBits'($sampled(inFields)), opBits'($sampled(outFields)));

  readyInitA: assert property (@(posedge clk)
      (reset_i || exceptionFlag_i) |=> phyRegRdy_o == archRdy)
    else noteFailure("ready init", opBits'(archRdy), opBits'($sampled(phyRegRdy_o)));

  readyTrackA: assert property (@(posedge clk) disable iff (reset_i) phyRegRdy_o == shadowRdy)
    else noteFailure("ready table", opBits'($sampled(shadowRdy)), opBits'($sampled(phyRegRdy_o)));

endmodule

bind regRead regReadChecker uChecker (.*);

//--- hw/operandBypass.sv
// Operand bypass select
`include "regRead_settings.svh"

module operandBypass (
  input  regReadPkg::physTagT  srcTag_i [2*`RR_LANES],
  input  regReadPkg::dataT     fileData_i [2*`RR_LANES],
  input  regReadPkg::bypassT   bypass_i [`RR_LANES],
  output regReadPkg::dataT     operand_o [2*`RR_LANES]
);

  import regReadPkg::*;

  localparam int numOperands = 2 * `RR_LANES;

  for (genvar s = 0; s < numOperands; s++) begin : gOperand
    logic [`RR_LANES-1:0] hit;
    dataT sel;

    // tag compare against every valid result on the bypass network.
    for (genvar p = 0; p < `RR_LANES; p++) begin : gPort
      assign hit[p] = bypass_i[p].valid && (bypass_i[p].dest == srcTag_i[s]);
    end

    // walk from the top port down so the lowest matching port is left.
    always_comb begin
      sel = fileData_i[s];
      for (int p = `RR_LANES - 1; p >= 0; p--) begin
        if (hit[p]) begin
          sel = bypass_i[p].data;
        end
      end
    end

    assign operand_o[s] = sel;
  end

endmodule

//--- hw/physRegFile.sv
// Physical register file
`include "regRead_settings.svh"

module physRegFile (
  input  logic                  clk,
  input  regReadPkg::physTagT   rdTag_i [2*`RR_LANES],
  output regReadPkg::dataT      rdData_o [2*`RR_LANES],
  input  logic [`RR_LANES-1:0]  wrEn_i,
  input  regReadPkg::physTagT   wrTag_i [`RR_LANES],
  input  regReadPkg::dataT      wrData_i [`RR_LANES]
);

  import regReadPkg::*;

  localparam int readPorts = 2 * `RR_LANES;

  // storage, contents are undefined until written.
  dataT regs [`RR_PHYS_REGS];

  // two read ports per lane, both asynchronous.
  for (genvar r = 0; r < readPorts; r++) begin : gRead
    assign rdData_o[r] = regs[rdTag_i[r]];
  end

  // later ports overwrite earlier ones, so the highest port wins a collision.
  always_ff @(posedge clk) begin
    for (int w = 0; w < `RR_LANES; w++) begin
      if (wrEn_i[w]) begin
        regs[wrTag_i[w]] <= wrData_i[w];
      end
    end
  end

endmodule

//--- hw/readyTable.sv
// Physical register ready table
`include "regRead_settings.svh"

module readyTable (
  input  logic                      clk,
  input  logic                      reset_i,
  input  logic                      exceptionFlag_i,
  input  regReadPkg::tagReqT        wakeup_i [`RR_LANES],
  input  regReadPkg::tagReqT        unmap_i [`RR_LANES],
  output logic [`RR_PHYS_REGS-1:0]  phyRegRdy_o
);

  // architectural registers hold committed values and start out ready.
  localparam logic [`RR_PHYS_REGS-1:0] initRdy = {
    {(`RR_PHYS_REGS - `RR_ARCH_REGS){1'b0}},
    {`RR_ARCH_REGS{1'b1}}
  };

  logic [`RR_PHYS_REGS-1:0] rdyQ;
  logic [`RR_PHYS_REGS-1:0] rdyNext;

  always_comb begin
    rdyNext = rdyQ;
    for (int u = 0; u < `RR_LANES; u++) begin
      if (unmap_i[u].valid) begin
        rdyNext[unmap_i[u].tag] = 1'b0;
      end
    end
    // wakeups are applied last and beat an unmap of the same tag.
    for (int k = 0; k < `RR_LANES; k++) begin
      if (wakeup_i[k].valid) begin
        rdyNext[wakeup_i[k].tag] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i || exceptionFlag_i) begin
      rdyQ <= initRdy;
    end else begin
      rdyQ <= rdyNext;
    end
  end

  assign phyRegRdy_o = rdyQ;

endmodule

//--- hw/regRead.sv
// Register read stage
`include "regRead_settings.svh"

module regRead (
  input  logic                          clk,
  input  logic                          reset_i,
  input  regReadPkg::issuePacketT       fuPacket_i [`RR_LANES],
  input  logic [`RR_LANES-1:0]          fuPacketValid_i,
  input  regReadPkg::bypassT            bypass_i [`RR_LANES],
  input  regReadPkg::tagReqT            wakeup_i [`RR_LANES],
  input  regReadPkg::tagReqT            unmap_i [`RR_LANES],
  input  logic                          ctrlVerified_i,
  input  logic                          ctrlMispredict_i,
  input  logic [`RR_CHECKPOINT_LOG-1:0] ctrlCheckpoint_i,
  input  logic                          recoverFlag_i,
  input  logic                          exceptionFlag_i,
  output regReadPkg::readPacketT        fuPacket_o [`RR_LANES],
  output logic [`RR_LANES-1:0]          fuPacketValid_o,
  output logic [`RR_PHYS_REGS-1:0]      phyRegRdy_o
);

  import regReadPkg::*;

  physTagT srcTag [2*`RR_LANES];
  dataT fileData [2*`RR_LANES];
  dataT operand [2*`RR_LANES];
  logic [`RR_LANES-1:0] wrEn;
  physTagT wrTag [`RR_LANES];
  dataT wrData [`RR_LANES];
  logic mispredictEvent;

  assign mispredictEvent = ctrlVerified_i & ctrlMispredict_i;

  // results are still forwarded during recovery, only the write is dropped.
  for (genvar p = 0; p < `RR_LANES; p++) begin : gWrite
    assign wrEn[p] = bypass_i[p].valid & ~recoverFlag_i;
    assign wrTag[p] = bypass_i[p].dest;
    assign wrData[p] = bypass_i[p].data;
  end

  for (genvar l = 0; l < `RR_LANES; l++) begin : gLane
    assign srcTag[2*l] = fuPacket_i[l].src1;
    assign srcTag[2*l+1] = fuPacket_i[l].src2;

    assign fuPacket_o[l] = '{
      packet: fuPacket_i[l],
      srcData1: operand[2*l],
      srcData2: operand[2*l+1]
    };

    // squash anything younger than the mispredicted branch.
    assign fuPacketValid_o[l] = fuPacketValid_i[l] &
        ~(mispredictEvent & fuPacket_i[l].branchMask[ctrlCheckpoint_i]);
  end

  physRegFile uRegFile (
    .clk      (clk),
    .rdTag_i  (srcTag),
    .rdData_o (fileData),
    .wrEn_i   (wrEn),
    .wrTag_i  (wrTag),
    .wrData_i (wrData)
  );

  operandBypass uBypass (
    .srcTag_i   (srcTag),
    .fileData_i (fileData),
    .bypass_i   (bypass_i),
    .operand_o  (operand)
  );

  readyTable uReady (
    .clk             (clk),
    .reset_i         (reset_i),
    .exceptionFlag_i (exceptionFlag_i),
    .wakeup_i        (wakeup_i),
    .unmap_i         (unmap_i),
    .phyRegRdy_o     (phyRegRdy_o)
  );

endmodule

//--- hw/regReadPkg.sv
// Register read types
`include "regRead_settings.svh"

package regReadPkg;

  typedef logic [`RR_PHYS_LOG-1:0] physTagT;

  typedef logic [`RR_DATA_W-1:0] dataT;

  // functional unit class carried with the packet.
  typedef enum logic [2:0] {
    OP_ALU,
    OP_MUL,
    OP_LOAD,
    OP_STORE,
    OP_BRANCH
  } opcodeT;

  // issued instruction as it leaves the issue queue.
  typedef struct packed {
    logic [`RR_CHECKPOINTS-1:0] branchMask;
    physTagT src1;
    physTagT src2;
    physTagT dest;
    opcodeT opcode;
  } issuePacketT;

  // packet with both source operands attached.
  typedef struct packed {
    issuePacketT packet;
    dataT srcData1;
    dataT srcData2;
  } readPacketT;

  // result broadcast from a functional unit, also a file write port.
  typedef struct packed {
    logic valid;
    physTagT dest;
    dataT data;
  } bypassT;

  // wakeup or unmap request on the ready table.
  typedef struct packed {
    logic valid;
    physTagT tag;
  } tagReqT;

endpackage

//--- hw/regRead_settings.svh
// Register read sizes
`ifndef REGREAD_SETTINGS_SVH
`define REGREAD_SETTINGS_SVH

// issue lanes, also the count of bypass, wakeup and unmap ports.
`define RR_LANES 2

// physical register file.
`define RR_PHYS_REGS 64
`define RR_PHYS_LOG 6

// registers that are mapped and ready out of reset.
`define RR_ARCH_REGS 32

`define RR_DATA_W 32

// branch checkpoints tracked in the branch mask.
`define RR_CHECKPOINTS 4
`define RR_CHECKPOINT_LOG 2

`endif

//--- run.sh
#!/usr/bin/env bash
# Builds and runs the register read regression with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module regReadTb -f sim.f -o regReadSim
status=$?
if [ "$status" -ne 0 ]; then
  echo "build failed with status $status" >&2
  exit "$status"
fi

# keep running past an assertion error so the testbench reports it.
./obj_dir/regReadSim +verilator+error+limit+100
status=$?
if [ "$status" -ne 0 ]; then
  echo "simulation failed with status $status" >&2
  exit "$status"
fi

echo "simulation finished cleanly"
exit 0

//--- sim.f
+incdir+hw
hw/regReadPkg.sv
hw/physRegFile.sv
hw/operandBypass.sv
hw/readyTable.sv
hw/regRead.sv
dv/regRead_assertions.sv
dv/regReadTb.sv
